/* Makefile */
# Verilator build and run for the framebuffer display testbench

VERILATOR ?= verilator
TOP       ?= fb_display_tb
FILELIST  ?= fb_display_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bram_sdp.sv */
/* simple dual-port RAM, one write port and one registered read port
   both ports on clk_pix, read data valid 1 cycle after the address
   contents start at zero, read during write returns the old data */

`timescale 1ns/10ps

module bram_sdp #(
    parameter type data_t = logic [7:0],  // payload type
    parameter int  DEPTH  = 256
) (
    input  logic                     clk_pix,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] addr_write,
    input  data_t                    data_in,
    input  logic [$clog2(DEPTH)-1:0] addr_read,
    output data_t                    data_out
);

    data_t mem [DEPTH] = '{default: '0};  // power-up contents

    // write port
    always_ff @(posedge clk_pix) begin
        if (we) begin
            mem[addr_write] <= data_in;
        end
    end

    // read port, registered
    always_ff @(posedge clk_pix) begin
        data_out <= mem[addr_read];
    end

    // catch writes past the end when DEPTH is not a power of two
    a_write_range: assert property (
        @(posedge clk_pix) we |-> (int'(addr_write) < DEPTH)
    ) else $error("bram_sdp: write address %0d beyond depth %0d", addr_write, DEPTH);

endmodule

/* display_timings.sv */
/* 640x480 position counters, sync and enable decode
   outputs are combinational from the counters, no added latency
   counters restart at (0,0) on reset */

`timescale 1ns/10ps

module display_timings import fb_pkg::*; (
    input  logic   clk_pix,
    input  logic   rst_n,
    output coord_t sx,      // horizontal position
    output coord_t sy,      // vertical position
    output logic   hsync,   // active low
    output logic   vsync,   // active low
    output logic   de,      // visible area
    output logic   vblank   // below the visible area
);

    logic line_end;
    logic frame_end;

    assign line_end  = (sx == coord_t'(h_res_full - 1));
    assign frame_end = (sy == coord_t'(v_res_full - 1));

    // position counters
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            sx <= '0;
            sy <= '0;
        end else if (line_end) begin
            sx <= '0;
            sy <= frame_end ? '0 : sy + 1'b1;  // wrap at bottom of frame
        end else begin
            sx <= sx + 1'b1;
        end
    end

    // sync pulses, low inside the bounds
    always_comb begin
        hsync = ~(sx >= coord_t'(h_sync_start) && sx <= coord_t'(h_sync_end));
        vsync = ~(sy >= coord_t'(v_sync_start) && sy <= coord_t'(v_sync_end));
    end

    assign de     = (sx < coord_t'(h_res)) && (sy < coord_t'(v_res));
    assign vblank = (sy >= coord_t'(v_res));  // whole line, incl. hblank

    // counters never leave the frame
    a_pos_range: assert property (
        @(posedge clk_pix) disable iff (!rst_n)
        (sx < coord_t'(h_res_full)) && (sy < coord_t'(v_res_full))
    ) else $error("display_timings: position out of frame (%0d,%0d)", sx, sy);

endmodule

/* fb_display_input.txt */
# P idx rgb | L x0 x1 y cidx | C x y rgb
# idx, coordinates and cidx decimal, rgb 12-bit hex
P 1 f00
P 2 0f0
P 3 00f
L 0 9 0 1
L 150 300 5 2
L 20 10 7 3
L 0 50 120 3
L 40 60 119 3
C 0 0 f00
C 9 0 f00
C 10 0 000
C 159 5 0f0
C 160 5 000
C 149 5 000
C 15 7 000
C 40 119 00f
C 60 119 00f
C 61 119 000
P 0 123
C 10 0 123
C 200 100 000
C 100 50 123

/* fb_display_tb.sv */
/* fb_display_top testbench reading stimulus and expected colours from fb_display_input.txt
   own framebuffer and palette model assumes both RAMs start at zero
   pixel position is found by counting vga_de cycles after the vsync pulse */

`timescale 1ns/10ps

module fb_display_tb;

    localparam int frame_cycles = 800 * 525;
    localparam int rand_lines   = 6;

    logic clk_pix = 1'b0;
    logic rst_n   = 1'b0;
    logic line_start = 1'b0;
    logic [9:0] line_x0 = '0, line_x1 = '0, line_y = '0;
    logic [3:0] line_cidx = '0;
    logic pal_we = 1'b0;
    logic [3:0] pal_idx = '0;
    logic [11:0] pal_colr = '0;
    logic line_busy, vga_hsync, vga_vsync, vga_de;
    logic [3:0] vga_r, vga_g, vga_b;

    logic [3:0]  fb_model [19200];  // expected framebuffer indices
    logic [11:0] pal_model [16];
    int   pending [int];            // C checks keyed by y*640+x
    byte  kind_q [$];
    int   a_q [$], b_q [$], c_q [$], d_q [$];
    int   errors = 0, checks = 0, tests = 0, failed_tests = 0;
    int   frames_needed = 0;
    logic [31:0] rand_state = 32'd84;

    fb_display_top DUT (.*);

    always #4 clk_pix = ~clk_pix;  // 8 ns period

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rand_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rand_state = x;
        return x;
    endfunction

    task automatic compare_value(string name, int expected, int actual);
        checks++;
        assert (expected == actual) else begin
            $display("Fail %0t %s expected %0h got %0h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic end_test(string name, int err_before);
        tests++;
        if (errors != err_before) failed_tests++;
        $display("test %s: %s", name, (errors == err_before) ? "ok" : "errors");
    endtask

    task automatic write_palette(int idx, int colr);
        @(posedge clk_pix);
        pal_we   <= 1'b1;
        pal_idx  <= idx[3:0];
        pal_colr <= colr[11:0];
        @(posedge clk_pix);
        pal_we   <= 1'b0;
        pal_model[idx[3:0]] = colr[11:0];
    endtask

    // drive one line command and follow busy until it drops
    task automatic draw_line(int x0, int x1, int y, int cidx);
        int clip, n;
        bit empty;
        clip  = (x1 > 159) ? 159 : x1;
        empty = (x0 > clip) || (y >= 120);
        n = 0;
        while (line_busy && n < 2 * frame_cycles) begin
            @(negedge clk_pix);
            n++;
        end
        @(posedge clk_pix);
        line_start <= 1'b1;
        line_x0 <= x0[9:0];
        line_x1 <= x1[9:0];
        line_y <= y[9:0];
        line_cidx <= cidx[3:0];
        @(posedge clk_pix);
        line_start <= 1'b0;
        n = 0;
        @(negedge clk_pix);
        compare_value("line_busy", 1, line_busy);
        while (line_busy && n < 2 * frame_cycles) begin
            n++;
            @(negedge clk_pix);
        end
        assert (!line_busy) else begin
            $display("line (%0d..%0d, %0d) still busy after two frames", x0, x1, y);
            errors++;
        end
        if (empty) begin
            compare_value("busy_cycles", 1, n);
        end else begin
            for (int x = x0; x <= clip; x++) begin
                fb_model[y * 160 + x] = cidx[3:0];
            end
        end
    endtask

    // compare every visible pixel of the next frame with the model and pending checks
    task automatic check_frame();
        int n, x, y, exp;
        while (vga_vsync) @(negedge clk_pix);
        while (!vga_vsync) @(negedge clk_pix);
        n = 0;
        while (n < 640 * 480) begin
            @(negedge clk_pix);
            if (vga_de) begin
                x = n % 640;
                y = n / 640;
                exp = (x < 160 && y < 120) ? pal_model[fb_model[y * 160 + x]] : 0;
                compare_value($sformatf("rgb(%0d,%0d)", x, y), exp, {vga_r, vga_g, vga_b});
                if (pending.exists(n)) compare_value("file_rgb", pending[n], {vga_r, vga_g, vga_b});
                n++;
            end
        end
        pending.delete();
    endtask

    task automatic measure_sync();
        int h_low, h_fall, v_low, de_run, lines;
        logic ph, pv;
        h_low  = 0;
        h_fall = -1;
        v_low  = 0;
        de_run = 0;
        lines  = 0;
        pv = 1'b0;
        while (!(pv && !vga_vsync)) begin
            pv = vga_vsync;
            @(negedge clk_pix);
        end
        ph = vga_hsync;
        for (int cyc = 0; cyc < frame_cycles; cyc++) begin
            if (!vga_hsync) h_low++;
            else if (h_low != 0) begin
                compare_value("hsync_low_cycles", 96, h_low);
                h_low = 0;
            end
            if (ph && !vga_hsync) begin
                if (h_fall >= 0) compare_value("hsync_period", 800, cyc - h_fall);
                h_fall = cyc;
            end
            if (!vga_vsync) v_low++;
            if (vga_de) de_run++;
            else if (de_run != 0) begin
                compare_value("de_per_line", 640, de_run);
                lines++;
                de_run = 0;
            end
            ph = vga_hsync;
            pv = vga_vsync;
            @(negedge clk_pix);
        end
        compare_value("vsync_low_cycles", 1600, v_low);
        compare_value("visible_lines", 480, lines);
        compare_value("vsync_period", 1, pv && !vga_vsync);  // next pulse starts on time
    endtask

    task automatic read_commands();
        int fd, a, b, c, d;
        byte k;
        string s;
        fd = $fopen("fb_display_input.txt", "r");
        assert (fd != 0) else begin
            $display("cannot open fb_display_input.txt");
            errors++;
        end
        while (fd != 0 && !$feof(fd)) begin
            if ($fgets(s, fd) == 0) break;
            if ($sscanf(s, "%c", k) < 1) continue;
            if (k == "P") void'($sscanf(s, "%c %d %h", k, a, b));
            else if (k == "L") void'($sscanf(s, "%c %d %d %d %d", k, a, b, c, d));
            else if (k == "C") void'($sscanf(s, "%c %d %d %h", k, a, b, c));
            else continue;  // comment or blank line
            kind_q.push_back(k);
            a_q.push_back(a);
            b_q.push_back(b);
            c_q.push_back(c);
            d_q.push_back(d);
        end
        if (fd != 0) $fclose(fd);
    endtask

    // watchdog armed once the command count is known
    initial begin
        wait (frames_needed > 0);
        #(real'(frames_needed + 4) * frame_cycles * 8.0);
        $display("watchdog expired, simulation did not finish in time");
        $display("Testbench failed");
        $finish;
    end

    initial begin
        int e, x0;
        foreach (fb_model[i]) fb_model[i] = '0;
        foreach (pal_model[i]) pal_model[i] = '0;
        read_commands();
        frames_needed = 3 + 2 * kind_q.size() + 2 * rand_lines + 2;

        // reset values and the first cycles after release
        e = errors;
        repeat (9) @(posedge clk_pix);
        @(negedge clk_pix);
        compare_value("vga_hsync", 1, vga_hsync);
        compare_value("vga_vsync", 1, vga_vsync);
        compare_value("vga_de", 0, vga_de);
        compare_value("vga_rgb", 0, {vga_r, vga_g, vga_b});
        compare_value("line_busy", 0, line_busy);
        @(posedge clk_pix);
        rst_n <= 1'b1;
        repeat (3) begin
            @(negedge clk_pix);
            compare_value("vga_hsync", 1, vga_hsync);
            compare_value("vga_vsync", 1, vga_vsync);
            compare_value("vga_de", 0, vga_de);
            compare_value("vga_rgb", 0, {vga_r, vga_g, vga_b});
        end
        end_test("reset", e);

        e = errors;
        measure_sync();
        end_test("sync_timing", e);

        e = errors;
        for (int i = 0; i < kind_q.size(); i++) begin
            if (kind_q[i] != "C" && pending.size() != 0) check_frame();
            case (kind_q[i])
                "P": write_palette(a_q[i], b_q[i]);
                "L": draw_line(a_q[i], b_q[i], c_q[i], d_q[i]);
                default: pending[b_q[i] * 640 + a_q[i]] = c_q[i];
            endcase
        end
        if (pending.size() != 0) check_frame();
        end_test("file_commands", e);

        // random palette entries and spans with some clipped or off the framebuffer
        e = errors;
        for (int i = 0; i < rand_lines; i++) begin
            write_palette(i + 8, next_rand() % 4096);
            x0 = next_rand() % 170;
            draw_line(x0, x0 + next_rand() % 60, next_rand() % 130, i + 8);
        end
        check_frame();
        end_test("random_lines", e);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* fb_display_top.f */
fb_pkg.sv
display_timings.sv
bram_sdp.sv
fb_line_drawer.sv
fb_scanout.sv
fb_display_top.sv
fb_display_tb.sv

/* fb_display_top.sv */
/* 640x480 display with a 160x120 4-bit framebuffer and a writable 16-entry CLUT
   clk_pix and rst_n come from outside, no clock generation here
   vga outputs lag the position counters by scan_latency cycles */

`timescale 1ns/10ps

module fb_display_top import fb_pkg::*; (
    input  logic       clk_pix,
    input  logic       rst_n,
    // line drawing command
    input  logic       line_start,
    input  coord_t     line_x0,
    input  coord_t     line_x1,
    input  coord_t     line_y,
    input  cidx_t      line_cidx,
    output logic       line_busy,
    // palette write, usable at any time
    input  logic       pal_we,
    input  cidx_t      pal_idx,
    input  colr_t      pal_colr,
    // vga
    output logic       vga_hsync,
    output logic       vga_vsync,
    output logic       vga_de,
    output logic [3:0] vga_r,
    output logic [3:0] vga_g,
    output logic [3:0] vga_b
);

    coord_t   sx, sy;
    logic     hsync, vsync, de, vblank;
    logic     fb_we;
    fb_addr_t fb_addr_write;
    fb_addr_t fb_addr_read;
    cidx_t    fb_cidx_write;
    cidx_t    fb_cidx_read;   // also the clut read address
    colr_t    clut_colr;

    display_timings timings_inst (
        .clk_pix, .rst_n,
        .sx, .sy, .hsync, .vsync, .de, .vblank
    );

    fb_line_drawer drawer_inst (
        .clk_pix, .rst_n,
        .line_start, .line_x0, .line_x1, .line_y, .line_cidx,
        .vblank,
        .line_busy, .fb_we, .fb_addr_write, .fb_cidx_write
    );

    // framebuffer, one colour index per pixel
    bram_sdp #(
        .data_t (cidx_t),
        .DEPTH  (fb_pixels)
    ) fb_inst (
        .clk_pix,
        .we         (fb_we),
        .addr_write (fb_addr_write),
        .data_in    (fb_cidx_write),
        .addr_read  (fb_addr_read),
        .data_out   (fb_cidx_read)
    );

    // colour lookup table, loaded from the palette port
    bram_sdp #(
        .data_t (colr_t),
        .DEPTH  (clut_depth)
    ) clut_inst (
        .clk_pix,
        .we         (pal_we),
        .addr_write (pal_idx),
        .data_in    (pal_colr),
        .addr_read  (fb_cidx_read),
        .data_out   (clut_colr)
    );

    fb_scanout scanout_inst (
        .clk_pix, .rst_n,
        .sx, .sy, .hsync, .vsync, .de,
        .fb_addr_read,
        .clut_colr,
        .vga_hsync, .vga_vsync, .vga_de,
        .vga_r, .vga_g, .vga_b
    );

endmodule

/* fb_line_drawer.sv */
/* draws one clipped horizontal line per command into the framebuffer
   writes only while vblank is high, one pixel per cycle, pausing otherwise
   line_start is ignored while line_busy is high */

`timescale 1ns/10ps

module fb_line_drawer import fb_pkg::*; (
    input  logic     clk_pix,
    input  logic     rst_n,
    input  logic     line_start,     // single-cycle command strobe
    input  coord_t   line_x0,
    input  coord_t   line_x1,
    input  coord_t   line_y,
    input  cidx_t    line_cidx,
    input  logic     vblank,
    output logic     line_busy,
    output logic     fb_we,
    output fb_addr_t fb_addr_write,
    output cidx_t    fb_cidx_write
);

    coord_t   x1_clip;     // x1 limited to last fb column
    logic     cmd_empty;   // nothing to draw
    logic     accept;
    fb_addr_t row_base;
    fb_addr_t addr_end;    // last address to write
    logic     empty_q;     // latched empty flag
    cidx_t    cidx_q;

    // command decode for the accept cycle
    always_comb begin
        x1_clip   = (line_x1 > coord_t'(fb_width - 1)) ? coord_t'(fb_width - 1) : line_x1;
        cmd_empty = (line_x0 > x1_clip) || (line_y >= coord_t'(fb_height));
        row_base  = fb_addr_t'(line_y) * fb_addr_t'(fb_width);  // y * 160
    end

    assign accept = line_start && !line_busy;

    // control state
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            line_busy <= 1'b0;
            empty_q   <= 1'b0;
        end else if (accept) begin
            line_busy <= 1'b1;
            empty_q   <= cmd_empty;
        end else if (line_busy && empty_q) begin
            line_busy <= 1'b0;  // empty command ends after one busy cycle
        end else if (fb_we && fb_addr_write == addr_end) begin
            line_busy <= 1'b0;  // last pixel written this cycle
        end
    end

    // write address and colour index
    always_ff @(posedge clk_pix) begin
        if (accept) begin
            fb_addr_write <= row_base + fb_addr_t'(line_x0);
            addr_end      <= row_base + fb_addr_t'(x1_clip);
            cidx_q        <= line_cidx;
        end else if (fb_we) begin
            fb_addr_write <= fb_addr_write + 1'b1;  // next pixel along the row
        end
    end

    // write whenever there is work and the display is in vertical blanking
    assign fb_we         = line_busy && !empty_q && vblank;
    assign fb_cidx_write = cidx_q;

    a_we_vblank: assert property (
        @(posedge clk_pix) disable iff (!rst_n)
        fb_we |-> vblank
    ) else $error("fb_line_drawer: framebuffer write outside vblank");

    a_we_busy: assert property (
        @(posedge clk_pix) disable iff (!rst_n)
        fb_we |-> line_busy
    ) else $error("fb_line_drawer: framebuffer write while idle");

    // writes stay within the latched span
    a_we_range: assert property (
        @(posedge clk_pix) disable iff (!rst_n)
        fb_we |-> (fb_addr_write <= addr_end)
    ) else $error("fb_line_drawer: write at %0d past line end %0d", fb_addr_write, addr_end);

endmodule

/* fb_pkg.sv */
/* shared constants and pixel types for the 640x480 framebuffer display
   timing values assume a 25.175 MHz pixel clock (25 MHz works on most monitors)
   framebuffer is fixed at 160x120 with 4-bit colour indices */

package fb_pkg;

    // visible area and full frame incl. blanking
    localparam int h_res      = 640;
    localparam int v_res      = 480;
    localparam int h_res_full = 800;
    localparam int v_res_full = 525;

    // sync pulse bounds, inclusive, both pulses active low
    localparam int h_sync_start = 656;
    localparam int h_sync_end   = 751;
    localparam int v_sync_start = 490;
    localparam int v_sync_end   = 491;

    // framebuffer geometry
    localparam int fb_width  = 160;
    localparam int fb_height = 120;
    localparam int fb_pixels = fb_width * fb_height;  // 19200 entries
    localparam int fb_addrw  = $clog2(fb_pixels);      // 15 bits

    localparam int clut_depth = 16;  // one entry per colour index

    // counters to vga ports: fb read, clut read, output reg
    localparam int scan_latency = 3;

    typedef logic [9:0]          coord_t;    // screen or fb coordinate
    typedef logic [fb_addrw-1:0] fb_addr_t;
    typedef logic [3:0]          cidx_t;     // colour index
    typedef logic [11:0]         colr_t;     // {r, g, b}, 4 bits each

endpackage

/* fb_scanout.sv */
/* framebuffer read address generation and VGA output stage
   fb_addr_read is for the current position, colour arrives 2 cycles later
   syncs and de are delayed to match, total latency is scan_latency */

`timescale 1ns/10ps

module fb_scanout import fb_pkg::*; (
    input  logic       clk_pix,
    input  logic       rst_n,
    input  coord_t     sx,
    input  coord_t     sy,
    input  logic       hsync,
    input  logic       vsync,
    input  logic       de,
    output fb_addr_t   fb_addr_read,
    input  colr_t      clut_colr,     // from clut, 2 cycles after address
    output logic       vga_hsync,
    output logic       vga_vsync,
    output logic       vga_de,
    output logic [3:0] vga_r,
    output logic [3:0] vga_g,
    output logic [3:0] vga_b
);

    localparam int pipe_len = scan_latency - 1;  // fb read + clut read

    logic                fb_active;  // position inside 160x120
    logic                frame_end;
    logic [pipe_len-1:0] active_p;
    logic [pipe_len-1:0] hsync_p;
    logic [pipe_len-1:0] vsync_p;
    logic [pipe_len-1:0] de_p;

    assign fb_active = (sx < coord_t'(fb_width)) && (sy < coord_t'(fb_height));
    assign frame_end = (sx == coord_t'(h_res_full - 1)) && (sy == coord_t'(v_res_full - 1));

    // read address, ready ahead of the pixel it belongs to
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            fb_addr_read <= '0;
        end else if (frame_end) begin
            fb_addr_read <= '0;  // back to top-left for the next frame
        end else if (fb_active) begin
            fb_addr_read <= fb_addr_read + 1'b1;
        end
    end

    // match the memory path
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            active_p <= '0;
            hsync_p  <= '1;  // syncs idle high
            vsync_p  <= '1;
            de_p     <= '0;
        end else begin
            active_p <= {active_p[pipe_len-2:0], fb_active};
            hsync_p  <= {hsync_p[pipe_len-2:0], hsync};
            vsync_p  <= {vsync_p[pipe_len-2:0], vsync};
            de_p     <= {de_p[pipe_len-2:0], de};
        end
    end

    // output register
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            vga_hsync <= 1'b1;
            vga_vsync <= 1'b1;
            vga_de    <= 1'b0;
            {vga_r, vga_g, vga_b} <= '0;
        end else begin
            vga_hsync <= hsync_p[pipe_len-1];
            vga_vsync <= vsync_p[pipe_len-1];
            vga_de    <= de_p[pipe_len-1];
            {vga_r, vga_g, vga_b} <= active_p[pipe_len-1] ? clut_colr : '0;  // black outside fb
        end
    end

    // whole fb has been scanned once the first row below it starts
    a_addr_count: assert property (
        @(posedge clk_pix) disable iff (!rst_n)
        (sx == '0 && sy == coord_t'(fb_height)) |-> (fb_addr_read == fb_addr_t'(fb_pixels))
    ) else $error("fb_scanout: read address %0d at end of fb area", fb_addr_read);

endmodule
